// ==== Bender.yml ====
package:
  name: mipsMulticycle

sources:
  # RTL, package first
  - logic/mipsPkg.sv
  - logic/registerFile.sv
  - logic/aluUnit.sv
  - logic/multicycleControl.sv
  - logic/mipsDatapath.sv
  - logic/mipsCore.sv

  # testbench, top module mipsCoreTb
  - target: test
    files:
      - dv/tbClock.sv
      - dv/tbMemory.sv
      - dv/mipsCoreTb.sv

// ==== build.f ====
logic/mipsPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/multicycleControl.sv
logic/mipsDatapath.sv
logic/mipsCore.sv
dv/tbClock.sv
dv/tbMemory.sv
dv/mipsCoreTb.sv

// ==== dv/mipsCoreTb.sv ====
// --------------------------------------------------------------------------
// Multicycle MIPS core testbench
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;

  logic                          clk;
  logic                          reset;
  logic [mipsPkg::dataWidth-1:0] readData;
  mipsPkg::memReq_t              memReq;

  mipsPkg::instr_t  prog [0:63];      // program image
  int               progLen;
  mipsPkg::memReq_t expected [0:15];  // stores in program order
  int               expCount;
  int unsigned      seed;

  tbClock clkGen_i (.clk(clk), .reset(reset));

  tbMemory mem_i (.clk(clk), .memReq(memReq), .readData(readData));

  mipsCore dut_i (
    .clk      (clk),
    .reset    (reset),
    .readData (readData),
    .memReq   (memReq)
  );

  function automatic mipsPkg::instr_t rInstr(input mipsPkg::funct_t funct,
      input logic [mipsPkg::regAddrWidth-1:0] rs, rt, rd);
    mipsPkg::instr_t w;
    w             = '0;  // shamt stays zero
    w.rFmt.opcode = mipsPkg::rType;
    w.rFmt.rs     = rs;
    w.rFmt.rt     = rt;
    w.rFmt.rd     = rd;
    w.rFmt.funct  = funct;
    return w;
  endfunction

  function automatic mipsPkg::instr_t iInstr(input mipsPkg::opcode_t op,
      input logic [mipsPkg::regAddrWidth-1:0] rs, rt, input logic [15:0] imm);
    mipsPkg::instr_t w;
    w.iFmt.opcode = op;
    w.iFmt.rs     = rs;
    w.iFmt.rt     = rt;
    w.iFmt.imm    = imm;
    return w;
  endfunction

  function automatic mipsPkg::instr_t jInstr(input logic [25:0] target);
    mipsPkg::instr_t w;
    w.jFmt.opcode = mipsPkg::j;
    w.jFmt.target = target;  // word index, region 0
    return w;
  endfunction

  function automatic logic [31:0] signExtend(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  task automatic beginProgram();
    clkGen_i.startReset();  // core held while memory changes
    mem_i.fillPattern();
    progLen  = 0;
    expCount = 0;
  endtask

  task automatic emit(input mipsPkg::instr_t w);
    prog[progLen] = w;
    progLen++;
  endtask

  task automatic emitHalt();
    emit(jInstr(26'(progLen)));  // j to itself
  endtask

  task automatic expectStore(input logic [31:0] adr, input logic [31:0] data);
    expected[expCount].adr       = adr;
    expected[expCount].writeData = data;
    expected[expCount].memWrite  = 1'b1;
    expCount++;
  endtask

  task automatic checkStore(input mipsPkg::memReq_t want, input mipsPkg::memReq_t got);
    if (got !== want) begin
      $display("error at %0t ns: memReq expected adr=%h writeData=%h memWrite=%b,",
        $time, want.adr, want.writeData, want.memWrite,
        " actual adr=%h writeData=%h memWrite=%b",
        got.adr, got.writeData, got.memWrite);
      $display("TEST FAILED");
      $fatal(1, "store mismatch");
    end
  endtask

  task automatic waitStore(input string testName, input int index,
      output mipsPkg::memReq_t seen);
    int   cycles;
    logic found;
    found = 1'b0;
    for (cycles = 0; cycles < 200 && !found; cycles++) begin
      @(negedge clk);  // mid-cycle, port settled
      found = memReq.memWrite;
    end
    if (!found) begin
      $display("TEST FAILED");
      $display("%s: store %0d to address %h never arrived within 200 cycles",
        testName, index, expected[index].adr);
      $fatal(1, "store timeout");
    end else begin
      seen = memReq;
    end
  endtask

  // core should now spin in its halt loop
  task automatic checkQuiet(input string testName);
    int   cycles;
    logic stray;
    stray = 1'b0;
    for (cycles = 0; cycles < 40 && !stray; cycles++) begin
      @(negedge clk);
      stray = memReq.memWrite;
    end
    if (stray) begin
      $display("%s: unexpected store to address %h with data %h",
        testName, memReq.adr, memReq.writeData);
      $display("TEST FAILED");
      $fatal(1, "extra store");
    end
  endtask

  task automatic runProgram(input string testName);
    mipsPkg::memReq_t seen;
    for (int i = 0; i < progLen; i++) mem_i.loadWord(i, prog[i]);
    clkGen_i.endReset();
    for (int i = 0; i < expCount; i++) begin
      waitStore(testName, i, seen);
      checkStore(expected[i], seen);
    end
    checkQuiet(testName);
  endtask

  // rd = $3, then sw $3 to offset($0)
  task automatic emitRStore(input mipsPkg::funct_t funct,
      input logic [4:0] rs, rt, input logic [15:0] offset);
    emit(rInstr(funct, rs, rt, 5'd3));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd3, offset));
  endtask

  task automatic rTypeTest();
    logic [15:0] immA, immB, immC;
    logic [31:0] a, b;
    immA = 16'($urandom());
    immB = 16'($urandom());
    immC = 16'($urandom());
    a    = signExtend(immA) | {16'h0000, immB};
    b    = signExtend(immC);
    beginProgram();
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd1, immA));
    emit(iInstr(mipsPkg::ori, 5'd1, 5'd1, immB));  // $1 = a
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd2, immC));  // $2 = b
    emitRStore(mipsPkg::fAdd, 5'd1, 5'd2, 16'h0100);
    emitRStore(mipsPkg::fSub, 5'd1, 5'd2, 16'h0104);
    emitRStore(mipsPkg::fAnd, 5'd1, 5'd2, 16'h0108);
    emitRStore(mipsPkg::fOr, 5'd1, 5'd2, 16'h010c);
    emitRStore(mipsPkg::fSlt, 5'd1, 5'd2, 16'h0110);
    emitRStore(mipsPkg::fSlt, 5'd2, 5'd1, 16'h0114);  // both directions
    emitHalt();
    expectStore(32'h100, a + b);
    expectStore(32'h104, a - b);
    expectStore(32'h108, a & b);
    expectStore(32'h10c, a | b);
    expectStore(32'h110, {31'b0, $signed(a) < $signed(b)});
    expectStore(32'h114, {31'b0, $signed(b) < $signed(a)});
    runProgram("rType");
  endtask

  task automatic immediateTest();
    logic [15:0] negImm, highImm;
    negImm  = 16'($urandom()) | 16'h8000;
    highImm = 16'($urandom()) | 16'h8000;
    beginProgram();
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd5, negImm));
    emit(iInstr(mipsPkg::ori, 5'd0, 5'd6, highImm));
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd0, 16'h1234));  // $0 must stay zero
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd5, 16'h0140));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd6, 16'h0144));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd0, 16'h0148));
    emitHalt();
    expectStore(32'h140, {16'hffff, negImm});
    expectStore(32'h144, {16'h0000, highImm});
    expectStore(32'h148, 32'h0);
    runProgram("immediate");
  endtask

  task automatic memoryTest();
    logic [31:0] word;
    word = $urandom();
    beginProgram();
    mem_i.loadWord(128, word);  // address 0x200
    emit(iInstr(mipsPkg::lw, 5'd0, 5'd8, 16'h0200));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd8, 16'h0208));  // copy as loaded
    emit(iInstr(mipsPkg::addi, 5'd8, 5'd8, 16'h0001));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd8, 16'h0204));
    emitHalt();
    expectStore(32'h208, word);
    expectStore(32'h204, word + 32'd1);
    runProgram("memory");
  endtask

  task automatic branchCase(input logic isBne, input logic taken);
    logic [15:0]      x, y;
    logic             equal;
    mipsPkg::opcode_t op;
    equal = (taken != isBne);  // beq takes on equal, bne on unequal
    op    = mipsPkg::beq;
    if (isBne) op = mipsPkg::bne;
    x     = 16'($urandom());
    y     = equal ? x : x ^ 16'h0001;
    beginProgram();
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd1, x));
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd2, y));
    emit(iInstr(op, 5'd1, 5'd2, 16'd2));  // to word 5
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd1, 16'h0180));  // fall through
    emitHalt();
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd2, 16'h0184));  // target
    emitHalt();
    if (taken) expectStore(32'h184, signExtend(y));
    else       expectStore(32'h180, signExtend(x));
    runProgram(isBne ? "bne" : "beq");
  endtask

  task automatic jumpTest();
    logic [15:0] v;
    v = 16'($urandom());
    beginProgram();
    emit(iInstr(mipsPkg::addi, 5'd0, 5'd1, v));
    emit(jInstr(26'd3));
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd1, 16'h01c0));  // skipped
    emit(iInstr(mipsPkg::sw, 5'd0, 5'd1, 16'h01c4));
    emitHalt();
    expectStore(32'h1c4, signExtend(v));
    runProgram("jump");
  endtask

  initial begin
    seed = 32'h05a5_ddbb;
    void'($urandom(seed));
    rTypeTest();
    immediateTest();
    memoryTest();
    branchCase(1'b0, 1'b1);
    branchCase(1'b0, 1'b0);
    branchCase(1'b1, 1'b1);
    branchCase(1'b1, 1'b0);
    jumpTest();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
// --------------------------------------------------------------------------
// Testbench clock and reset
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;  // core held from time zero
    forever #50 clk = ~clk;  // 100 ns period
  end

  // assert on a falling edge
  task automatic startReset();
    @(negedge clk);
    reset = 1'b1;
  endtask

  // ten full cycles, released on a falling edge
  task automatic endReset();
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

endmodule

`default_nettype wire

// ==== dv/tbMemory.sv ====
// --------------------------------------------------------------------------
// Unified memory model
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tbMemory (
  input  wire                           clk,
  input  mipsPkg::memReq_t              memReq,
  output logic [mipsPkg::dataWidth-1:0] readData
);

  logic [mipsPkg::dataWidth-1:0] words [0:255];  // 1 KB, word indexed

  assign readData = words[memReq.adr[9:2]];  // same-cycle read

  always @(posedge clk) begin
    if (memReq.memWrite) begin
      words[memReq.adr[9:2]] <= memReq.writeData;  // store strobe
    end
  end

  // every word unique, built from the full index
  task automatic fillPattern();
    for (int i = 0; i < 256; i++) begin
      words[i] = {~i[7:0], 8'h5a, i[7:0], 8'hc3};
    end
  endtask

  // program and data preload
  task automatic loadWord(input int index, input logic [mipsPkg::dataWidth-1:0] word);
    words[index] = word;
  endtask

  initial fillPattern();

endmodule

`default_nettype wire

// ==== logic/aluUnit.sv ====
// --------------------------------------------------------------------------
// ALU with zero flag
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
  input  logic [mipsPkg::dataWidth-1:0] srcA,
  input  logic [mipsPkg::dataWidth-1:0] srcB,
  input  mipsPkg::aluOp_t               aluOp,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);

  logic                          invertB;   // sub and slt
  logic [mipsPkg::dataWidth-1:0] operandB;  // srcB or its complement
  logic [mipsPkg::dataWidth-1:0] sum;       // shared adder output
  logic                          overflow;  // signed overflow of sum
  logic                          lessThan;

  assign invertB  = (aluOp == mipsPkg::aluSub) || (aluOp == mipsPkg::aluSlt);
  assign operandB = invertB ? ~srcB : srcB;
  assign sum      = srcA + operandB + {{(mipsPkg::dataWidth-1){1'b0}}, invertB};

  // same operand signs but result sign flipped
  assign overflow = (srcA[mipsPkg::dataWidth-1] == operandB[mipsPkg::dataWidth-1]) &&
                    (sum[mipsPkg::dataWidth-1] != srcA[mipsPkg::dataWidth-1]);
  assign lessThan = sum[mipsPkg::dataWidth-1] ^ overflow;  // true signed compare

  always_comb begin
    case (aluOp)
      mipsPkg::aluAnd: result = srcA & srcB;
      mipsPkg::aluOr:  result = srcA | srcB;
      mipsPkg::aluSlt: result = {{(mipsPkg::dataWidth-1){1'b0}}, lessThan};
      default:         result = sum;  // add and sub
    endcase
  end

  assign zero = (result == '0);  // beq / bne condition

endmodule

`default_nettype wire

// ==== logic/mipsCore.sv ====
// --------------------------------------------------------------------------
// Multicycle MIPS core top
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
  input  wire                           clk,
  input  wire                           reset,
  input  logic [mipsPkg::dataWidth-1:0] readData,  // same-cycle memory read
  output mipsPkg::memReq_t              memReq
);

  mipsPkg::ctrl_t   ctrl;    // sequencer to datapath
  mipsPkg::status_t status;  // datapath to sequencer

  multicycleControl control_i (
    .clk    (clk),
    .reset  (reset),
    .status (status),
    .ctrl   (ctrl)
  );

  mipsDatapath datapath_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl),
    .readData (readData),
    .status   (status),
    .memReq   (memReq)
  );

endmodule

`default_nettype wire

// ==== logic/mipsDatapath.sv ====
// --------------------------------------------------------------------------
// Multicycle MIPS datapath
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mipsDatapath (
  input  wire                           clk,
  input  wire                           reset,
  input  mipsPkg::ctrl_t                ctrl,
  input  logic [mipsPkg::dataWidth-1:0] readData,
  output mipsPkg::status_t              status,
  output mipsPkg::memReq_t              memReq
);

  logic [mipsPkg::dataWidth-1:0] pc;
  mipsPkg::instr_t               instr;    // held instruction word
  logic [mipsPkg::dataWidth-1:0] dataReg;  // load data
  logic [mipsPkg::dataWidth-1:0] regA;
  logic [mipsPkg::dataWidth-1:0] regB;
  logic [mipsPkg::dataWidth-1:0] aluOut;

  logic [mipsPkg::dataWidth-1:0]    readDataA, readDataB;
  logic [mipsPkg::regAddrWidth-1:0] writeAddr;
  logic [mipsPkg::dataWidth-1:0]    writeBack;
  logic [mipsPkg::dataWidth-1:0]    signImm, extImm, immShifted;
  logic [mipsPkg::dataWidth-1:0]    srcA, srcB;
  logic [mipsPkg::dataWidth-1:0]    aluResult;
  logic                             aluZero;
  logic [mipsPkg::dataWidth-1:0]    jumpTarget;
  logic [mipsPkg::dataWidth-1:0]    nextPc;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= '0;
      instr   <= '0;
      dataReg <= '0;
      regA    <= '0;
      regB    <= '0;
      aluOut  <= '0;
    end else begin
      if (ctrl.pcEn)    pc    <= nextPc;
      if (ctrl.irWrite) instr <= readData;  // fetch only
      dataReg <= readData;
      regA    <= readDataA;
      regB    <= readDataB;
      aluOut  <= aluResult;
    end
  end

  assign writeAddr = ctrl.regDst ? instr.rFmt.rd : instr.rFmt.rt;
  assign writeBack = ctrl.memToReg ? dataReg : aluOut;

  registerFile regFile_i (
    .clk       (clk),
    .regWrite  (ctrl.regWrite),
    .readAddrA (instr.rFmt.rs),
    .readAddrB (instr.rFmt.rt),
    .writeAddr (writeAddr),
    .writeData (writeBack),
    .readDataA (readDataA),
    .readDataB (readDataB)
  );

  // immediate forms, zero extension for ori
  assign signImm    = {{16{instr.iFmt.imm[15]}}, instr.iFmt.imm};
  assign extImm     = ctrl.zeroExtImm ? {16'b0, instr.iFmt.imm} : signImm;
  assign immShifted = {signImm[mipsPkg::dataWidth-3:0], 2'b00};

  assign srcA = ctrl.aluSrcA ? regA : pc;

  always_comb begin
    case (ctrl.aluSrcB)
      mipsPkg::srcBReg:  srcB = regB;
      mipsPkg::srcBFour: srcB = 32'd4;
      mipsPkg::srcBImm:  srcB = extImm;
      default:           srcB = immShifted;
    endcase
  end

  aluUnit alu_i (
    .srcA   (srcA),
    .srcB   (srcB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // pc already holds pc+4 here, its top nibble picks the region
  assign jumpTarget = {pc[mipsPkg::dataWidth-1:28], instr.jFmt.target, 2'b00};

  always_comb begin
    case (ctrl.pcSrc)
      mipsPkg::pcSrcAlu:    nextPc = aluResult;
      mipsPkg::pcSrcAluOut: nextPc = aluOut;
      default:              nextPc = jumpTarget;
    endcase
  end

  assign status.opcode = instr.rFmt.opcode;
  assign status.funct  = instr.rFmt.funct;
  assign status.zero   = aluZero;

  assign memReq.adr       = ctrl.iOrD ? aluOut : pc;
  assign memReq.writeData = regB;          // rt value for sw
  assign memReq.memWrite  = ctrl.memWrite;

  storeAligned: assert property (@(posedge clk) disable iff (reset)
    ctrl.memWrite |-> memReq.adr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/mipsPkg.sv ====
// --------------------------------------------------------------------------
// Multicycle MIPS shared types
// --------------------------------------------------------------------------
`default_nettype none

package mipsPkg;

  localparam int dataWidth    = 32;                // data and address width
  localparam int regAddrWidth = 5;                 // register index width
  localparam int regCount     = 1 << regAddrWidth; // architectural registers

  // aluSrcB selections
  localparam logic [1:0] srcBReg   = 2'b00;  // B register
  localparam logic [1:0] srcBFour  = 2'b01;  // pc increment
  localparam logic [1:0] srcBImm   = 2'b10;  // extended immediate
  localparam logic [1:0] srcBImmSh = 2'b11;  // branch offset, word scaled

  // pcSrc selections
  localparam logic [1:0] pcSrcAlu    = 2'b00;  // live alu result
  localparam logic [1:0] pcSrcAluOut = 2'b01;  // branch target from decode
  localparam logic [1:0] pcSrcJump   = 2'b10;  // pseudo-direct jump target

  typedef enum logic [5:0] {
    rType = 6'b000000,
    j     = 6'b000010,
    beq   = 6'b000100,
    bne   = 6'b000101,
    addi  = 6'b001000,
    ori   = 6'b001101,
    lw    = 6'b100011,
    sw    = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    fAdd = 6'b100000,
    fSub = 6'b100010,
    fAnd = 6'b100100,
    fOr  = 6'b100101,
    fSlt = 6'b101010
  } funct_t;

  // bit 2 selects the inverted operand and carry in
  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOp_t;

  typedef enum logic [3:0] {
    fetch, decode, memAdr, memRd, memWb, memWr, rTypeEx,
    rTypeWb, beqEx, bneEx, addiEx, oriEx, immWb, jumpEx
  } ctrlState_t;

  typedef struct packed {
    opcode_t                 opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;  // unused by the kept set
    funct_t                  funct;
  } rFormat_t;

  typedef struct packed {
    opcode_t                 opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [15:0]             imm;
  } iFormat_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;  // word index within the 256 MB region
  } jFormat_t;

  typedef union packed {
    rFormat_t rFmt;
    iFormat_t iFmt;
    jFormat_t jFmt;
  } instr_t;

  typedef struct packed {
    logic       pcEn;
    logic       irWrite;
    logic       regWrite;
    logic       memWrite;
    logic       iOrD;       // 1: data address from aluOut
    logic       memToReg;   // 1: write back the data register
    logic       regDst;     // 1: rd, else rt
    logic       aluSrcA;    // 1: A register, else pc
    logic [1:0] aluSrcB;
    logic [1:0] pcSrc;
    logic       zeroExtImm;
    aluOp_t     aluOp;
  } ctrl_t;

  typedef struct packed {
    opcode_t opcode;
    funct_t  funct;
    logic    zero;
  } status_t;

  typedef struct packed {
    logic [dataWidth-1:0] adr;
    logic [dataWidth-1:0] writeData;
    logic                 memWrite;
  } memReq_t;

endpackage

`default_nettype wire

// ==== logic/multicycleControl.sv ====
// --------------------------------------------------------------------------
// Multicycle instruction sequencer
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module multicycleControl (
  input  wire              clk,
  input  wire              reset,
  input  mipsPkg::status_t status,
  output mipsPkg::ctrl_t   ctrl
);

  mipsPkg::ctrlState_t state, nextState;
  mipsPkg::aluOp_t     functOp;  // R-type operation from funct
  logic                pcWrite;  // unconditional pc load
  logic                branch;   // conditional pc load

  always_ff @(posedge clk or posedge reset) begin
    if (reset) state <= mipsPkg::fetch;
    else       state <= nextState;
  end

  always_comb begin
    nextState = mipsPkg::fetch;  // last state of every instruction
    case (state)
      mipsPkg::fetch: nextState = mipsPkg::decode;
      mipsPkg::decode: begin
        case (status.opcode)
          mipsPkg::lw,
          mipsPkg::sw:    nextState = mipsPkg::memAdr;
          mipsPkg::rType: nextState = mipsPkg::rTypeEx;
          mipsPkg::beq:   nextState = mipsPkg::beqEx;
          mipsPkg::bne:   nextState = mipsPkg::bneEx;
          mipsPkg::addi:  nextState = mipsPkg::addiEx;
          mipsPkg::ori:   nextState = mipsPkg::oriEx;
          mipsPkg::j:     nextState = mipsPkg::jumpEx;
          default:        nextState = mipsPkg::fetch;  // undefined, drop it
        endcase
      end
      mipsPkg::memAdr:
        nextState = (status.opcode == mipsPkg::lw) ? mipsPkg::memRd : mipsPkg::memWr;
      mipsPkg::memRd:   nextState = mipsPkg::memWb;
      mipsPkg::rTypeEx: nextState = mipsPkg::rTypeWb;
      mipsPkg::addiEx,
      mipsPkg::oriEx:   nextState = mipsPkg::immWb;  // shared rt write back
      default:          nextState = mipsPkg::fetch;
    endcase
  end

  always_comb begin
    case (status.funct)
      mipsPkg::fSub: functOp = mipsPkg::aluSub;
      mipsPkg::fAnd: functOp = mipsPkg::aluAnd;
      mipsPkg::fOr:  functOp = mipsPkg::aluOr;
      mipsPkg::fSlt: functOp = mipsPkg::aluSlt;
      default:       functOp = mipsPkg::aluAdd;  // fAdd and unknown
    endcase
  end

  always_comb begin
    ctrl    = '0;  // idle word, pc and aluSrcA select pc
    pcWrite = 1'b0;
    branch  = 1'b0;
    ctrl.aluOp = mipsPkg::aluAdd;
    case (state)
      mipsPkg::fetch: begin
        ctrl.irWrite = 1'b1;
        ctrl.aluSrcB = mipsPkg::srcBFour;  // pc + 4
        ctrl.pcSrc   = mipsPkg::pcSrcAlu;
        pcWrite      = 1'b1;
      end
      mipsPkg::decode:  ctrl.aluSrcB = mipsPkg::srcBImmSh;  // branch target to aluOut
      mipsPkg::memAdr: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::srcBImm;
      end
      mipsPkg::memRd:   ctrl.iOrD = 1'b1;
      mipsPkg::memWb: begin
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::memWr: begin
        ctrl.iOrD     = 1'b1;
        ctrl.memWrite = 1'b1;  // one-cycle store strobe
      end
      mipsPkg::rTypeEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::srcBReg;
        ctrl.aluOp   = functOp;
      end
      mipsPkg::rTypeWb: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::beqEx,
      mipsPkg::bneEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::srcBReg;
        ctrl.aluOp   = mipsPkg::aluSub;  // compare by difference
        ctrl.pcSrc   = mipsPkg::pcSrcAluOut;
        branch       = 1'b1;
      end
      mipsPkg::addiEx: begin
        ctrl.aluSrcA = 1'b1;
        ctrl.aluSrcB = mipsPkg::srcBImm;
      end
      mipsPkg::oriEx: begin
        ctrl.aluSrcA    = 1'b1;
        ctrl.aluSrcB    = mipsPkg::srcBImm;
        ctrl.zeroExtImm = 1'b1;
        ctrl.aluOp      = mipsPkg::aluOr;
      end
      mipsPkg::immWb:   ctrl.regWrite = 1'b1;
      mipsPkg::jumpEx: begin
        ctrl.pcSrc = mipsPkg::pcSrcJump;
        pcWrite    = 1'b1;
      end
      default: ctrl.irWrite = 1'b0;
    endcase
    // bne takes the branch on a nonzero difference
    ctrl.pcEn = pcWrite | (branch & (status.zero ^ (state == mipsPkg::bneEx)));
  end

  decodeOpcodeKnown: assert property (@(posedge clk) disable iff (reset)
    state == mipsPkg::decode |-> status.opcode inside {mipsPkg::rType, mipsPkg::lw,
      mipsPkg::sw, mipsPkg::beq, mipsPkg::bne, mipsPkg::addi, mipsPkg::ori, mipsPkg::j});

  // a store strobe only ever ends a sw sequence
  noStoreWithWriteBack: assert property (@(posedge clk) disable iff (reset)
    ctrl.memWrite |-> !ctrl.regWrite && status.opcode == mipsPkg::sw);

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
// --------------------------------------------------------------------------
// Register file, two read ports
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module registerFile (
  input  wire                               clk,
  input  logic                              regWrite,
  input  logic [mipsPkg::regAddrWidth-1:0]  readAddrA,
  input  logic [mipsPkg::regAddrWidth-1:0]  readAddrB,
  input  logic [mipsPkg::regAddrWidth-1:0]  writeAddr,
  input  logic [mipsPkg::dataWidth-1:0]     writeData,
  output logic [mipsPkg::dataWidth-1:0]     readDataA,
  output logic [mipsPkg::dataWidth-1:0]     readDataB
);

  logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::regCount];  // entry 0 never read

  always_ff @(posedge clk) begin
    if (regWrite) begin
      regs[writeAddr] <= writeData;  // write to $0 lands but is masked on read
    end
  end

  // combinational reads, $0 forced to zero
  always_comb begin
    readDataA = '0;
    readDataB = '0;
    if (readAddrA != '0) readDataA = regs[readAddrA];
    if (readAddrB != '0) readDataB = regs[readAddrB];
  end

endmodule

`default_nettype wire
